/* bitserial_core.f */
+incdir+sim
design/bitserial_core_pkg.sv
design/core_state.sv
design/core_decode.sv
design/core_alu.sv
design/core_rf.sv
design/core_ctrl.sv
design/core_mem_if.sv
design/core_top.sv
sim/tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bit-serial core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f bitserial_core.f --top-module tb_core \
   -Mdir obj_dir -o tb_core || { echo "build failed"; exit 1; }

./obj_dir/tb_core > sim.log 2>&1
cat sim.log

! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/tb_core_tasks.svh */
`ifndef TB_CORE_TASKS_SVH
`define TB_CORE_TASKS_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// also used for loads with the opcode given by the caller
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
   return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
   assert (exp === act) else begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1);
   end
endtask

function automatic int pick_delay();
   return int'($urandom_range(max_delay, 0));
endfunction

// executes one instruction on the register model
// kind is 0 for none, 1 for a load and 2 for a store
task automatic model_step(input logic [31:0] ins, output int kind,
                          output logic [31:0] maddr, output logic [31:0] sdata);
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] res;
   logic [31:0] next_pc;
   logic        taken;
   a = ref_regs[ins[19:15]];
   b = (ins[6:2] == 5'b01100) ? ref_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
   next_pc = ref_pc + 32'd4;
   kind = 0;
   maddr = 32'd0;
   sdata = 32'd0;
   case (opcode_e'(ins[6:2]))
      op_opimm, op_op: begin
         case (ins[14:12])
            3'b010:  res = {31'd0, $signed(a) < $signed(b)};
            3'b011:  res = {31'd0, a < b};
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: res = (ins[5] & ins[30]) ? a - b : a + b;
         endcase
         ref_regs[ins[11:7]] = res;
      end
      op_lui: ref_regs[ins[11:7]] = {ins[31:12], 12'd0};
      op_jal: begin
         ref_regs[ins[11:7]] = next_pc;
         next_pc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      op_branch: begin
         b = ref_regs[ins[24:20]];
         taken = ins[14] ? ($signed(a) < $signed(b)) : (a == b);
         if (taken ^ ins[12])
            next_pc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      op_load: begin
         kind = 1;
         maddr = a + b;
      end
      op_store: begin
         kind = 2;
         maddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
         sdata = ref_regs[ins[24:20]];
      end
      default: ;
   endcase
   ref_regs[0] = 32'd0;
   ref_pc = next_pc;
endtask

task automatic reset_dut();
   @(posedge i_clk);
   i_rst <= 1'b1;
   repeat (10) @(posedge i_clk);
   i_rst <= 1'b0;
   @(posedge i_clk);
   @(negedge i_clk);
   // the first fetch is requested right after reset
   check_eq("o_ibus_cyc", 32'd1, {31'd0, o_ibus_cyc});
   check_eq("o_ibus_adr", RESET_PC, {o_ibus_adr, 2'b00});
   check_eq("o_dbus_cyc", 32'd0, {31'd0, o_dbus_cyc});
endtask

task automatic wait_fetch();
   do @(negedge i_clk); while (!o_ibus_cyc);
   check_eq("o_ibus_adr", ref_pc, {o_ibus_adr, 2'b00});
   check_eq("o_dbus_cyc", 32'd0, {31'd0, o_dbus_cyc});
   sig = sig * 33 ^ {o_ibus_adr, 2'b00};
endtask

// runs prog from RESET_PC until the model reaches the end of the program
task automatic run_program();
   logic [31:0] ins;
   logic [31:0] maddr;
   logic [31:0] sdata;
   int          kind;
   for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(12'(i * 4), 5'd0, 3'd0, 5'd0, 7'b0010011);
      dmem[i] = 32'h5a3c_0000 ^ (32'(i) * 32'h0001_0203);
   end
   foreach (prog[i])
      imem[i] = prog[i];
   cycle_limit = cycle_cnt + 40 + prog.size() * (80 + 2 * max_delay);
   ref_pc = RESET_PC;
   reset_dut();
   while (ref_pc != 32'(prog.size() * 4)) begin
      wait_fetch();
      ins = imem[ref_pc[9:2]];
      repeat (pick_delay()) @(negedge i_clk);
      @(posedge i_clk);
      i_ibus_ack <= 1'b1;
      i_ibus_rdt <= ins;
      @(posedge i_clk);
      i_ibus_ack <= 1'b0;
      model_step(ins, kind, maddr, sdata);
      if (kind != 0) begin
         do @(negedge i_clk); while (!o_dbus_cyc);
         check_eq("o_dbus_we", 32'(kind == 2), {31'd0, o_dbus_we});
         check_eq("o_dbus_adr", {maddr[31:2], 2'b00}, {o_dbus_adr, 2'b00});
         if (kind == 2) begin
            check_eq("o_dbus_dat", sdata, o_dbus_dat);
            dmem[maddr[9:2]] = sdata;
            sig = sig * 33 ^ o_dbus_dat;
         end else if (ins[11:7] != 5'd0) begin
            ref_regs[ins[11:7]] = dmem[maddr[9:2]];
         end
         repeat (pick_delay()) @(negedge i_clk);
         @(posedge i_clk);
         i_dbus_ack <= 1'b1;
         i_dbus_rdt <= dmem[maddr[9:2]];
         @(posedge i_clk);
         i_dbus_ack <= 1'b0;
      end
   end
   // the next fetch marks the end of the last instruction
   wait_fetch();
endtask

task automatic test_alu_ops();
   logic [2:0] f3 [7] = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111, 3'b010, 3'b011};
   prog.delete();
   prog.push_back(enc_i(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_i(12'hd2b, 5'd0, 3'b000, 5'd2, 7'b0010011));
   for (int k = 0; k < 7; k++) begin
      prog.push_back(enc_r((k == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3[k], 5'(k + 3)));
      prog.push_back(enc_sw(12'(12'h100 + k * 4), 5'(k + 3), 5'd0));
   end
   // set-less-than with the operands swapped and a negative addi
   prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd10));
   prog.push_back(enc_sw(12'h11c, 5'd10, 5'd0));
   prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd11));
   prog.push_back(enc_sw(12'h120, 5'd11, 5'd0));
   prog.push_back(enc_i(12'hff0, 5'd2, 3'b000, 5'd12, 7'b0010011));
   prog.push_back(enc_sw(12'h124, 5'd12, 5'd0));
   run_program();
endtask

task automatic test_load_add();
   prog.delete();
   prog.push_back({20'hfedc1, 5'd1, 7'b0110111});
   prog.push_back(enc_i(12'h080, 5'd0, 3'b010, 5'd2, 7'b0000011));
   prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
   prog.push_back(enc_sw(12'h140, 5'd3, 5'd0));
   run_program();
endtask

task automatic test_branches();
   prog.delete();
   prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011));
   prog.push_back(enc_i(12'hffd, 5'd0, 3'b000, 5'd3, 7'b0010011));
   // taken and untaken pairs where any skipped slot would corrupt x1
   prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
   prog.push_back(enc_i(12'd100, 5'd1, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
   prog.push_back(enc_b(13'd8, 5'd1, 5'd3, 3'b100));
   prog.push_back(enc_i(12'd100, 5'd1, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_b(13'd8, 5'd1, 5'd3, 3'b101));
   prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b101));
   prog.push_back(enc_i(12'd100, 5'd1, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b100));
   prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b001));
   prog.push_back(enc_i(12'd100, 5'd1, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b000));
   prog.push_back(enc_sw(12'h180, 5'd1, 5'd0));
   run_program();
endtask

task automatic test_jal();
   prog.delete();
   prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_jal(21'd12, 5'd5));
   prog.push_back(enc_i(12'd2, 5'd0, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_i(12'd3, 5'd0, 3'b000, 5'd1, 7'b0010011));
   prog.push_back(enc_sw(12'h1c0, 5'd5, 5'd0));
   prog.push_back(enc_sw(12'h1c4, 5'd1, 5'd0));
   run_program();
endtask

`endif

/* sim/tb_core.sv */
`default_nettype none

module tb_core import bitserial_core_pkg::*; ();

   logic        i_clk;
   logic        i_rst;
   logic        i_ibus_ack;
   logic [31:0] i_ibus_rdt;
   logic        i_dbus_ack;
   logic [31:0] i_dbus_rdt;
   logic        o_ibus_cyc;
   logic [31:2] o_ibus_adr;
   logic        o_dbus_cyc;
   logic        o_dbus_we;
   logic [31:2] o_dbus_adr;
   logic [31:0] o_dbus_dat;

   // word-indexed instruction and data memories
   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [31:0] prog [$];

   // reference register model
   logic [31:0] ref_regs [32];
   logic [31:0] ref_pc;

   int unsigned cycle_cnt = 0;
   int unsigned cycle_limit = 0;
   int unsigned max_delay;
   // hash of the fetch addresses and store data seen on the DUT ports
   int unsigned sig;
   int unsigned sig_pass [2];

   core_top DUT (
      .i_clk(i_clk), .i_rst(i_rst),
      .o_ibus_cyc(o_ibus_cyc), .o_ibus_adr(o_ibus_adr),
      .i_ibus_ack(i_ibus_ack), .i_ibus_rdt(i_ibus_rdt),
      .o_dbus_cyc(o_dbus_cyc), .o_dbus_we(o_dbus_we),
      .o_dbus_adr(o_dbus_adr), .o_dbus_dat(o_dbus_dat),
      .i_dbus_ack(i_dbus_ack), .i_dbus_rdt(i_dbus_rdt)
   );

   always #20 i_clk = ~i_clk;

   // run limit grows with every program that is started
   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout: the core stopped fetching or answering at %0t", $time);
         $display("Test FAILED");
         $fatal(1);
      end
   end

   `include "tb_core_tasks.svh"

   initial begin
      i_clk      = 1'b0;
      i_rst      = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = 32'd0;
      i_dbus_ack = 1'b0;
      i_dbus_rdt = 32'd0;
      cycle_limit = 20;
      void'($urandom(32'h041d_de5c));
      for (int r = 0; r < 32; r++)
         ref_regs[r] = 32'd0;

      // first pass acks at once and the second one after random delays
      for (int p = 0; p < 2; p++) begin
         max_delay = (p == 0) ? 0 : 5;
         sig = 0;
         test_alu_ops();
         test_load_add();
         test_branches();
         test_jal();
         sig_pass[p] = sig;
      end
      check_eq("fetch/store signature", sig_pass[0], sig_pass[1]);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

/* design/core_top.sv */
`default_nettype none

module core_top import bitserial_core_pkg::*; (
   input  wire          i_clk,
   input  wire          i_rst,
   output logic         o_ibus_cyc,
   output logic [31:2]  o_ibus_adr,
   input  wire          i_ibus_ack,
   input  wire [31:0]   i_ibus_rdt,
   output logic         o_dbus_cyc,
   output logic         o_dbus_we,
   output logic [31:2]  o_dbus_adr,
   output logic [31:0]  o_dbus_dat,
   input  wire          i_dbus_ack,
   input  wire [31:0]   i_dbus_rdt
);

   // sequencing
   logic             cnt_en;
   logic [CNT_W-1:0] cnt;
   logic             cnt0;
   logic             cnt_done;
   logic             bufreg_en;
   logic             ctrl_pc_en;
   logic             ctrl_jump;
   logic             rf_rreq;
   logic             rf_wreq;
   logic             rf_rd_en;
   logic             rf_ready;

   // decode levels
   opcode_e          opcode;
   alu_op_e          alu_op;
   logic             branch_op;
   logic             cond_branch;
   logic             bne_or_bge;
   logic             mem_op;
   logic             slt_op;
   logic             rd_op;
   logic             op_b_imm;
   logic [4:0]       rs1_addr;
   logic [4:0]       rs2_addr;
   logic [4:0]       rd_addr;
   logic             imm_bit;

   // serial data bits
   logic             rs1_bit;
   logic             rs2_bit;
   logic             op_b_bit;
   logic             alu_result;
   logic             alu_cmp;
   logic             link_bit;
   logic             load_bit;
   logic             rd_wdata;
   logic             is_lui;

   assign is_lui   = (opcode == op_lui);
   assign op_b_bit = op_b_imm ? imm_bit : rs2_bit;
   // lui and jal write through ctrl, loads from the bus, the rest from the alu
   assign rd_wdata = (is_lui | (opcode == op_jal)) ? link_bit :
                     (mem_op ? load_bit : alu_result);

   core_state u_state (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_alu_cmp(alu_cmp), .i_rf_ready(rf_ready),
      .i_ibus_ack(i_ibus_ack), .i_dbus_ack(i_dbus_ack),
      .i_branch_op(branch_op), .i_cond_branch(cond_branch),
      .i_bne_or_bge(bne_or_bge), .i_mem_op(mem_op),
      .i_slt_op(slt_op), .i_rd_op(rd_op),
      .o_init(), .o_cnt_en(cnt_en), .o_cnt(cnt), .o_cnt0(cnt0),
      .o_cnt_done(cnt_done), .o_bufreg_en(bufreg_en),
      .o_ctrl_pc_en(ctrl_pc_en), .o_ctrl_jump(ctrl_jump),
      .o_rf_rreq(rf_rreq), .o_rf_wreq(rf_wreq), .o_rf_rd_en(rf_rd_en),
      .o_ibus_cyc(o_ibus_cyc), .o_dbus_cyc(o_dbus_cyc)
   );

   core_decode u_decode (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_ibus_ack(i_ibus_ack), .i_ibus_rdt(i_ibus_rdt),
      .i_cnt(cnt), .i_cnt_en(cnt_en),
      .o_opcode(opcode), .o_alu_op(alu_op),
      .o_branch_op(branch_op), .o_cond_branch(cond_branch),
      .o_bne_or_bge(bne_or_bge), .o_mem_op(mem_op), .o_mem_we(o_dbus_we),
      .o_slt_op(slt_op), .o_rd_op(rd_op), .o_op_b_imm(op_b_imm),
      .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
      .o_imm_bit(imm_bit)
   );

   core_alu u_alu (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_cnt_en(cnt_en), .i_cnt0(cnt0), .i_cnt_done(cnt_done),
      .i_alu_op(alu_op), .i_rs1_bit(rs1_bit), .i_op_b_bit(op_b_bit),
      .o_result_bit(alu_result), .o_cmp(alu_cmp)
   );

   // reads and the write-back pass both wait for ready
   core_rf u_rf (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_rreq(rf_rreq | rf_wreq), .i_wen(rf_rd_en),
      .i_cnt(cnt), .i_cnt_en(cnt_en),
      .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
      .i_wdata_bit(rd_wdata),
      .o_ready(rf_ready), .o_rs1_bit(rs1_bit), .o_rs2_bit(rs2_bit)
   );

   core_ctrl u_ctrl (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_pc_en(ctrl_pc_en), .i_jump(ctrl_jump),
      .i_cnt0(cnt0), .i_cnt_en(cnt_en),
      .i_imm_bit(imm_bit), .i_lui(is_lui),
      .o_pc_adr(o_ibus_adr), .o_rd_link_bit(link_bit)
   );

   core_mem_if u_mem_if (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_bufreg_en(bufreg_en), .i_addr_bit(alu_result), .i_rs2_bit(rs2_bit),
      .i_cnt_en(cnt_en), .i_dbus_ack(i_dbus_ack), .i_dbus_rdt(i_dbus_rdt),
      .o_dbus_adr(o_dbus_adr), .o_dbus_dat(o_dbus_dat), .o_load_bit(load_bit)
   );

endmodule

`default_nettype wire

/* design/core_mem_if.sv */
`default_nettype none

module core_mem_if import bitserial_core_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst,
   input  wire             i_bufreg_en,
   input  wire             i_addr_bit,
   input  wire             i_rs2_bit,
   input  wire             i_cnt_en,
   input  wire             i_dbus_ack,
   input  wire [31:0]      i_dbus_rdt,
   output logic [31:2]     o_dbus_adr,
   output logic [31:0]     o_dbus_dat,
   output logic            o_load_bit
);

   logic [XLEN-1:0] adr_sr;
   logic [XLEN-1:0] dat_sr;
   logic [XLEN-1:0] rdt_sr;

   // address from the alu sum shifted in lsb first
   always_ff @(posedge i_clk) begin
      if (i_rst)
         adr_sr <= '0;
      else if (i_bufreg_en)
         adr_sr <= {i_addr_bit, adr_sr[XLEN-1:1]};
   end

   // store data collected alongside the address
   always_ff @(posedge i_clk) begin
      if (i_rst)
         dat_sr <= '0;
      else if (i_bufreg_en)
         dat_sr <= {i_rs2_bit, dat_sr[XLEN-1:1]};
   end

   // load word captured on the ack and shifted out in the write-back pass
   always_ff @(posedge i_clk) begin
      if (i_rst)
         rdt_sr <= '0;
      else if (i_dbus_ack)
         rdt_sr <= i_dbus_rdt;
      else if (i_cnt_en)
         rdt_sr <= {1'b0, rdt_sr[XLEN-1:1]};
   end

   // word access drops the low address bits
   assign o_dbus_adr = adr_sr[31:2];
   assign o_dbus_dat = dat_sr;
   assign o_load_bit = rdt_sr[0];

endmodule

`default_nettype wire

/* design/core_ctrl.sv */
`default_nettype none

module core_ctrl import bitserial_core_pkg::*; (
   input  wire            i_clk,
   input  wire            i_rst,
   input  wire            i_pc_en,
   input  wire            i_jump,
   input  wire            i_cnt0,
   input  wire            i_cnt_en,
   input  wire            i_imm_bit,
   input  wire            i_lui,
   output logic [31:2]    o_pc_adr,
   output logic           o_rd_link_bit
);

   logic [XLEN-1:0] pc;
   logic            cnt1;
   logic            cnt2;
   logic            cy_off;
   logic            cy_four;
   logic            cin_off;
   logic            cin_four;
   logic            sum_off;
   logic            sum_four;

   // cnt0 delayed twice marks bit 2, the only set bit of the constant 4
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt1 <= 1'b0;
         cnt2 <= 1'b0;
      end else if (i_cnt_en) begin
         cnt1 <= i_cnt0;
         cnt2 <= cnt1;
      end
   end

   // two serial adders, pc + offset and pc + 4
   assign cin_off  = !i_cnt0 & cy_off;
   assign cin_four = !i_cnt0 & cy_four;
   assign sum_off  = pc[0] ^ i_imm_bit ^ cin_off;
   assign sum_four = pc[0] ^ cnt2 ^ cin_four;

   // pc shifts right, lsb first, new bits enter at the top
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc      <= RESET_PC;
         cy_off  <= 1'b0;
         cy_four <= 1'b0;
      end else if (i_pc_en) begin
         pc      <= {i_jump ? sum_off : sum_four, pc[XLEN-1:1]};
         cy_off  <= (pc[0] & i_imm_bit) | ((pc[0] ^ i_imm_bit) & cin_off);
         cy_four <= (pc[0] & cnt2) | ((pc[0] ^ cnt2) & cin_four);
      end
   end

   assign o_pc_adr = pc[31:2];

   // lui writes the immediate, jal the return address
   assign o_rd_link_bit = i_lui ? i_imm_bit : sum_four;

endmodule

`default_nettype wire

/* design/core_rf.sv */
`default_nettype none

module core_rf import bitserial_core_pkg::*; (
   input  wire              i_clk,
   input  wire              i_rst,
   input  wire              i_rreq,
   input  wire              i_wen,
   input  wire [CNT_W-1:0]  i_cnt,
   input  wire              i_cnt_en,
   input  wire [4:0]        i_rs1_addr,
   input  wire [4:0]        i_rs2_addr,
   input  wire [4:0]        i_rd_addr,
   input  wire              i_wdata_bit,
   output logic             o_ready,
   output logic             o_rs1_bit,
   output logic             o_rs2_bit
);

   logic [XLEN-1:0] regs [32];

   // one bit per cycle at the current index
   // a bit is read in the same cycle it gets overwritten, so rd may equal rs1
   always_ff @(posedge i_clk) begin
      if (i_cnt_en & i_wen)
         regs[i_rd_addr][i_cnt] <= i_wdata_bit;
   end

   // x0 reads as zero whatever was written there
   assign o_rs1_bit = (i_rs1_addr != 5'd0) & regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = (i_rs2_addr != 5'd0) & regs[i_rs2_addr][i_cnt];

   // ready the cycle after any request
   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_ready <= 1'b0;
      else
         o_ready <= i_rreq;
   end

endmodule

`default_nettype wire

/* design/core_alu.sv */
`default_nettype none

module core_alu import bitserial_core_pkg::*; (
   input  wire     i_clk,
   input  wire     i_rst,
   input  wire     i_cnt_en,
   input  wire     i_cnt0,
   input  wire     i_cnt_done,
   input  wire     alu_op_e i_alu_op,
   input  wire     i_rs1_bit,
   input  wire     i_op_b_bit,
   output logic    o_result_bit,
   output logic    o_cmp
);

   logic sub_en;
   logic b_bit;
   logic carry_in;
   logic carry_out;
   logic carry_r;
   logic sum;
   logic eq_now;
   logic eq_r;
   logic lt_now;
   logic cmp_r;

   // compare ops subtract too
   assign sub_en = (i_alu_op == alu_sub) | (i_alu_op == alu_slt) | (i_alu_op == alu_sltu);
   assign b_bit  = i_op_b_bit ^ sub_en;

   // carry is preset at bit 0, giving the +1 of two's complement
   assign carry_in  = i_cnt0 ? sub_en : carry_r;
   assign sum       = i_rs1_bit ^ b_bit ^ carry_in;
   assign carry_out = (i_rs1_bit & b_bit) | ((i_rs1_bit ^ b_bit) & carry_in);

   // equal so far, including the current bit
   assign eq_now = (i_cnt0 | eq_r) & (i_rs1_bit == i_op_b_bit);

   // unsigned: borrow out of the msb
   // signed: sign of the difference, or rs1 sign when operand signs differ
   assign lt_now = (i_alu_op == alu_sltu) ? !carry_out :
                   ((i_rs1_bit ^ i_op_b_bit) ? i_rs1_bit : sum);

   // valid at bit 31 of the init pass
   assign o_cmp = (i_alu_op == alu_sub) ? eq_now : lt_now;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
         cmp_r   <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= carry_out;
         eq_r    <= eq_now;
         // held for the slt write-back pass
         if (i_cnt_done)
            cmp_r <= o_cmp;
      end
   end

   always_comb begin
      case (i_alu_op)
         alu_slt,
         alu_sltu: o_result_bit = i_cnt0 & cmp_r;
         alu_xor:  o_result_bit = i_rs1_bit ^ i_op_b_bit;
         alu_or:   o_result_bit = i_rs1_bit | i_op_b_bit;
         alu_and:  o_result_bit = i_rs1_bit & i_op_b_bit;
         default:  o_result_bit = sum;
      endcase
   end

endmodule

`default_nettype wire

/* design/core_decode.sv */
`default_nettype none

module core_decode import bitserial_core_pkg::*; (
   input  wire              i_clk,
   input  wire              i_rst,
   input  wire              i_ibus_ack,
   input  wire [31:0]       i_ibus_rdt,
   input  wire [CNT_W-1:0]  i_cnt,
   input  wire              i_cnt_en,
   output opcode_e          o_opcode,
   output alu_op_e          o_alu_op,
   output logic             o_branch_op,
   output logic             o_cond_branch,
   output logic             o_bne_or_bge,
   output logic             o_mem_op,
   output logic             o_mem_we,
   output logic             o_slt_op,
   output logic             o_rd_op,
   output logic             o_op_b_imm,
   output logic [4:0]       o_rs1_addr,
   output logic [4:0]       o_rs2_addr,
   output logic [4:0]       o_rd_addr,
   output logic             o_imm_bit
);

   logic [31:0] ir;
   logic [2:0]  funct3;
   logic        arith;
   logic [31:0] imm;

   // instruction register, comes out of reset holding addi x0,x0,0
   always_ff @(posedge i_clk) begin
      if (i_rst)
         ir <= 32'h0000_0013;
      else if (i_ibus_ack)
         ir <= i_ibus_rdt;
   end

   assign funct3     = ir[14:12];
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];
   assign o_rd_addr  = ir[11:7];

   // classify, anything unknown falls to illegal and runs as a nop
   always_comb begin
      case (ir[6:2])
         5'b00000: o_opcode = op_load;
         5'b00100: o_opcode = op_opimm;
         5'b01000: o_opcode = op_store;
         5'b01100: o_opcode = op_op;
         5'b01101: o_opcode = op_lui;
         5'b11000: o_opcode = op_branch;
         5'b11011: o_opcode = op_jal;
         default:  o_opcode = op_illegal;
      endcase
   end

   assign arith         = (o_opcode == op_opimm) | (o_opcode == op_op);
   assign o_cond_branch = (o_opcode == op_branch);
   assign o_branch_op   = o_cond_branch | (o_opcode == op_jal);
   assign o_bne_or_bge  = funct3[0];
   assign o_mem_we      = (o_opcode == op_store);
   assign o_mem_op      = o_mem_we | (o_opcode == op_load);
   assign o_slt_op      = arith & (funct3[2:1] == 2'b01);
   assign o_rd_op       = arith | (o_opcode == op_lui) | (o_opcode == op_jal) |
                          (o_opcode == op_load);
   assign o_op_b_imm    = (o_opcode == op_opimm) | o_mem_op;

   // beq/bne test equality, blt/bge reuse the slt compare
   always_comb begin
      o_alu_op = alu_add;
      if (o_cond_branch) begin
         o_alu_op = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
      end else if (arith) begin
         case (funct3)
            3'b000:  o_alu_op = ((o_opcode == op_op) & ir[30]) ? alu_sub : alu_add;
            3'b010:  o_alu_op = alu_slt;
            3'b011:  o_alu_op = alu_sltu;
            3'b100:  o_alu_op = alu_xor;
            3'b110:  o_alu_op = alu_or;
            3'b111:  o_alu_op = alu_and;
            default: o_alu_op = alu_add;
         endcase
      end
   end

   // sign-extended immediate per format, I-type by default
   always_comb begin
      case (o_opcode)
         op_store:  imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
         op_branch: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
         op_lui:    imm = {ir[31:12], 12'd0};
         op_jal:    imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
         default:   imm = {{21{ir[31]}}, ir[30:20]};
      endcase
   end

   // quiet between passes
   assign o_imm_bit = i_cnt_en & imm[i_cnt];

endmodule

`default_nettype wire

/* design/core_state.sv */
`default_nettype none

module core_state import bitserial_core_pkg::*; (
   input  wire              i_clk,
   input  wire              i_rst,
   input  wire              i_alu_cmp,
   input  wire              i_rf_ready,
   input  wire              i_ibus_ack,
   input  wire              i_dbus_ack,
   input  wire              i_branch_op,
   input  wire              i_cond_branch,
   input  wire              i_bne_or_bge,
   input  wire              i_mem_op,
   input  wire              i_slt_op,
   input  wire              i_rd_op,
   output logic             o_init,
   output logic             o_cnt_en,
   output logic [CNT_W-1:0] o_cnt,
   output logic             o_cnt0,
   output logic             o_cnt_done,
   output logic             o_bufreg_en,
   output logic             o_ctrl_pc_en,
   output logic             o_ctrl_jump,
   output logic             o_rf_rreq,
   output logic             o_rf_wreq,
   output logic             o_rf_rd_en,
   output logic             o_ibus_cyc,
   output logic             o_dbus_cyc
);

   // index bits 4:2 count normally, bits 1:0 are a one-hot ring
   logic [2:0] cnt_hi;
   logic [3:0] cnt_r;
   logic       init_done;
   logic       stage_two_req;
   logic       boot;
   logic       two_stage_op;
   logic       take_branch;

   // branches, jal, slt and memory ops need a second pass
   assign two_stage_op = i_slt_op | i_mem_op | i_branch_op;
   assign o_init       = two_stage_op & !init_done;

   // ring is empty while idle
   assign o_cnt_en = |cnt_r;
   assign o_cnt    = {cnt_hi, cnt_r[3] | cnt_r[2], cnt_r[3] | cnt_r[1]};
   assign o_cnt0   = (cnt_hi == 3'd0) & cnt_r[0];

   // pc moves only in the final pass of an instruction
   assign o_ctrl_pc_en = o_cnt_en & !o_init;
   // address and store data are collected during the init pass
   assign o_bufreg_en  = o_cnt_en & o_init & i_mem_op;
   assign o_rf_rd_en   = i_rd_op & !o_init;

   // jal always jumps, branches when the compare matches the funct3 sense
   // only meaningful in the last init cycle
   assign take_branch = i_branch_op & (!i_cond_branch | (i_alu_cmp ^ i_bne_or_bge));

   // read request as soon as the instruction arrives
   assign o_rf_rreq = i_ibus_ack;
   // second pass starts after the data bus answers or after the stage-two strobe
   assign o_rf_wreq = (i_mem_op & i_dbus_ack) |
                      (stage_two_req & (i_slt_op | i_branch_op));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         boot          <= 1'b1;
         o_ibus_cyc    <= 1'b0;
         o_dbus_cyc    <= 1'b0;
         init_done     <= 1'b0;
         o_ctrl_jump   <= 1'b0;
         stage_two_req <= 1'b0;
         o_cnt_done    <= 1'b0;
         cnt_hi        <= 3'd0;
         cnt_r         <= 4'b0000;
      end else begin
         // first fetch right after reset, then one per finished instruction
         boot <= 1'b0;
         if (boot | (o_cnt_done & o_ctrl_pc_en))
            o_ibus_cyc <= 1'b1;
         else if (i_ibus_ack)
            o_ibus_cyc <= 1'b0;

         // data bus request from end of init until the ack
         if (o_cnt_done & o_init & i_mem_op)
            o_dbus_cyc <= 1'b1;
         else if (i_dbus_ack)
            o_dbus_cyc <= 1'b0;

         // init_done toggles at the end of each pass of a two-pass op
         if (o_cnt_done) begin
            init_done   <= o_init;
            o_ctrl_jump <= o_init & take_branch;
         end

         // one-cycle strobe in the idle slot after init
         stage_two_req <= o_cnt_done & o_init;

         // high during bit 31
         o_cnt_done <= (cnt_hi == 3'd7) & cnt_r[2];

         // ring is seeded by rf ready and stops once bit 31 is done
         cnt_hi <= cnt_hi + {2'd0, cnt_r[3]};
         cnt_r  <= {cnt_r[2:0], (cnt_r[3] & !o_cnt_done) | (i_rf_ready & !o_cnt_en)};
      end
   end

endmodule

`default_nettype wire

/* design/bitserial_core_pkg.sv */
`default_nettype none

package bitserial_core_pkg;

   // data path width and width of the serial bit index
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // first fetch address out of reset
   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // instruction classes, values follow opcode[6:2]
   typedef enum logic [4:0] {
      op_load    = 5'b00000,
      op_opimm   = 5'b00100,
      op_store   = 5'b01000,
      op_op      = 5'b01100,
      op_lui     = 5'b01101,
      op_branch  = 5'b11000,
      op_jal     = 5'b11011,
      op_illegal = 5'b11111
   } opcode_e;

   // serial alu functions
   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_slt,
      alu_sltu,
      alu_xor,
      alu_or,
      alu_and
   } alu_op_e;

endpackage

`default_nettype wire
